// ==== logic/ethSwitchPkg.sv ====
`default_nettype none

package ethSwitchPkg;

    // Info word pushed by the PHY receiver, one per packet
    typedef struct packed {
        logic        flush;       // Bad frame, drop without the host
        logic [6:0]  rsvd1;
        logic [7:0]  firstByte;   // First data byte, checked against the data FIFO
        logic [3:0]  rsvd0;
        logic [11:0] byteCount;   // Frame length in bytes
    } recvInfo_t;

    // Info word that closes a packet in the send FIFO
    typedef struct packed {
        logic        overflow;    // Send FIFO filled, packet is truncated
        logic [6:0]  rsvd;
        logic [7:0]  firstByte;   // Low byte of send word 0
        logic [15:0] byteCount;   // Response byte count from the host
    } sendInfo_t;

    typedef enum logic [2:0] {
        stIdle     = 3'd0,
        stRecvWait = 3'd1,        // recvRequest out, waiting for recvBusy
        stRecv     = 3'd2,
        stSendWait = 3'd3,        // sendRequest out, waiting for sendBusy
        stSend     = 3'd4
    } switchState_t;

    // FIFO sizes
    localparam int fifoDataDepth = 64;
    localparam int fifoInfoDepth = 4;

    // Debug window at 0x98..0x9f
    localparam logic [4:0]  dbgWindowBase = 5'h13;
    localparam logic [31:0] dbgSignature  = 32'h32474244;    // "DBG2" byte-swapped

    // Word indices inside a frame
    localparam logic [11:0] frameBeginWord = 12'd0;
    localparam logic [11:0] frameTypeWord  = 12'd6;          // Ethertype word

    // Single-cycle pulses toward the debug block
    typedef struct packed {
        logic pktValid;
        logic pktFlushed;
        logic pktSent;
        logic recvDone;           // Last word popped, valid or flushed
        logic sendDone;
    } switchEvents_t;

    // Level flags shown at debug quadlet 1
    typedef struct packed {
        logic curPortRecv;
        logic curPortSend;
        logic overflow;
        logic firstByteErr;
        logic ipv4;
    } switchStatus_t;

endpackage

`default_nettype wire

// ==== logic/portFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module portFifo #(
    parameter int width = 16,
    parameter int depth = 64              // Power of two
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              wrEn,
    input  wire [width-1:0]  wrData,
    input  wire              rdEn,
    output logic [width-1:0] rdData,      // Head word, valid while not empty
    output logic             full,
    output logic             empty
);

    logic [width-1:0] mem [depth];

    // Extra top bit tells full from empty
    logic [$clog2(depth):0] wrPtr;
    logic [$clog2(depth):0] rdPtr;

    always_ff @(posedge clk) begin
        if (wrEn && !full)
            mem[wrPtr[$clog2(depth)-1:0]] <= wrData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (wrEn && !full)
                wrPtr <= wrPtr + 1'b1;
            if (rdEn && !empty)
                rdPtr <= rdPtr + 1'b1;
        end
    end

    assign empty  = (wrPtr == rdPtr);
    assign full   = (wrPtr[$clog2(depth)] != rdPtr[$clog2(depth)])
                 && (wrPtr[$clog2(depth)-1:0] == rdPtr[$clog2(depth)-1:0]);
    assign rdData = mem[rdPtr[$clog2(depth)-1:0]];   // First word falls through

    // Callers honour the flags on both sides
    assert property (@(posedge clk) disable iff (rst)
        !(wrEn && full) && !(rdEn && empty));

endmodule

`default_nettype wire

// ==== logic/ethPortSwitch.sv ====
`timescale 1ns/1ps
`default_nettype none

module ethPortSwitch (
    input  wire              clk,
    input  wire              rst,
    input  wire [1:0]        portUp,
    // Receive FIFOs of both ports
    input  wire [1:0]        rxEmpty,
    input  wire [1:0]        rxInfoEmpty,
    input  wire [1:0][15:0]  rxWordIn,
    input  ethSwitchPkg::recvInfo_t [1:0] rxInfoIn,
    output logic [1:0]       rxRdEn,
    output logic [1:0]       rxInfoRdEn,
    // Send FIFOs of both ports
    input  wire [1:0]        txFull,
    input  wire [1:0]        txInfoFull,
    output logic [1:0]       txWrEn,
    output logic [1:0]       txInfoWrEn,
    output logic [15:0]      txWordOut,
    output ethSwitchPkg::sendInfo_t txInfoOut,
    // Host side
    input  wire              sendReq,
    input  wire              recvBusy,
    input  wire              sendBusy,
    input  wire [15:0]       sendWord,
    input  wire              responseRequired,
    input  wire [15:0]       responseByteCount,
    output logic             recvRequest,
    output logic             recvReady,
    output logic [15:0]      recvWord,
    output logic             sendRequest,
    output logic             sendReady,
    output logic             isForward,
    output ethSwitchPkg::switchEvents_t events,
    output ethSwitchPkg::switchStatus_t status
);

    ethSwitchPkg::switchState_t state;
    ethSwitchPkg::recvInfo_t    curInfo;

    logic        curPortRecv;
    logic        curPortSend;       // Follows curPortRecv
    logic [3:0]  strobe;            // One-hot word phase, rotates each cycle
    logic [11:0] wordCnt;           // Words done in the current packet
    logic [11:0] lastWord;          // Index of the final receive word
    logic        curPacketValid;
    logic [7:0]  recvFirstByte;
    logic [7:0]  sendFirstByte;
    logic        firstByteErr;
    logic        sendOverflow;
    logic        sendIpv4;

    logic forwardGo;
    logic takePacket;
    logic otherReady;
    logic stepWord;
    logic sendValid;

    assign curInfo = rxInfoIn[curPortRecv];

    // Idle decisions, in priority order
    assign forwardGo  = portUp[curPortSend] & sendReq & ~txFull[curPortSend];
    assign takePacket = (state == ethSwitchPkg::stIdle) & ~forwardGo
                      & portUp[curPortRecv] & ~rxInfoEmpty[curPortRecv];
    assign otherReady = portUp[~curPortRecv] & ~rxInfoEmpty[~curPortRecv];

    // A flush pops every cycle, a delivery once per phase
    assign stepWord  = (state == ethSwitchPkg::stRecv) & (curPacketValid ? strobe[2] : 1'b1);
    assign sendValid = (state == ethSwitchPkg::stSend) & sendBusy & strobe[1];

    assign recvReady = (state == ethSwitchPkg::stRecv) & curPacketValid & strobe[0];
    assign sendReady = (state == ethSwitchPkg::stSend) & sendBusy & strobe[0];
    assign recvWord  = rxWordIn[curPortRecv];
    assign txWordOut = {sendWord[7:0], sendWord[15:8]};   // Byte swap toward the PHY

    always_comb begin
        rxRdEn     = '0;
        rxInfoRdEn = '0;
        txWrEn     = '0;
        rxRdEn[curPortRecv]     = stepWord;
        rxInfoRdEn[curPortRecv] = takePacket;
        // Stop writing for good once the FIFO has filled
        txWrEn[curPortSend] = sendValid & ~txFull[curPortSend] & ~sendOverflow;
    end

    assign status = '{curPortRecv: curPortRecv, curPortSend: curPortSend,
                      overflow: sendOverflow, firstByteErr: firstByteErr, ipv4: sendIpv4};

    // ------------------------------
    // Switch FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        events     <= '0;               // Pulses only
        txInfoWrEn <= '0;
        if (rst) begin
            state          <= ethSwitchPkg::stIdle;
            curPortRecv    <= 1'b0;
            curPortSend    <= 1'b0;
            recvRequest    <= 1'b0;
            sendRequest    <= 1'b0;
            isForward      <= 1'b0;
            strobe         <= '0;
            wordCnt        <= '0;
            curPacketValid <= 1'b0;
            firstByteErr   <= 1'b0;
            sendOverflow   <= 1'b0;
            sendIpv4       <= 1'b0;
        end else begin
            case (state)
            ethSwitchPkg::stIdle: begin
                wordCnt   <= '0;
                isForward <= 1'b0;
                if (forwardGo) begin                  // Host-initiated forward
                    isForward   <= 1'b1;
                    sendRequest <= 1'b1;
                    state       <= ethSwitchPkg::stSendWait;
                end else if (takePacket) begin
                    lastWord          <= ((curInfo.byteCount + 12'd1) >> 1) - 12'd1;
                    recvFirstByte     <= curInfo.firstByte;
                    curPacketValid    <= ~curInfo.flush;
                    recvRequest       <= ~curInfo.flush;   // Host sees valid packets only
                    strobe            <= 4'b0001;
                    events.pktValid   <= ~curInfo.flush;
                    events.pktFlushed <= curInfo.flush;
                    state <= curInfo.flush ? ethSwitchPkg::stRecv : ethSwitchPkg::stRecvWait;
                end else if (otherReady) begin
                    curPortRecv <= ~curPortRecv;
                    curPortSend <= ~curPortRecv;
                end
            end

            ethSwitchPkg::stRecvWait: begin
                if (recvBusy) begin
                    recvRequest <= 1'b0;
                    state       <= ethSwitchPkg::stRecv;   // strobe already on recvReady
                end
            end

            ethSwitchPkg::stRecv: begin
                if (curPacketValid)
                    strobe <= {strobe[2:0], strobe[3]};
                // Word 0 must agree with the info word
                if (strobe[1] && wordCnt == ethSwitchPkg::frameBeginWord)
                    firstByteErr <= rxEmpty[curPortRecv] | (recvWord[15:8] != recvFirstByte);
                if (stepWord) begin
                    if (wordCnt == lastWord) begin
                        sendRequest     <= curPacketValid & responseRequired;
                        events.recvDone <= 1'b1;
                        state <= (curPacketValid & responseRequired) ?
                                 ethSwitchPkg::stSendWait : ethSwitchPkg::stIdle;
                    end else begin
                        wordCnt <= wordCnt + 12'd1;
                    end
                end
            end

            ethSwitchPkg::stSendWait: begin
                if (sendBusy) begin
                    sendRequest  <= 1'b0;
                    sendOverflow <= 1'b0;
                    strobe       <= 4'b0001;
                    wordCnt      <= '0;
                    state        <= ethSwitchPkg::stSend;
                end
            end

            ethSwitchPkg::stSend: begin
                if (sendBusy) begin
                    strobe <= {strobe[2:0], strobe[3]};
                    if (strobe[1]) begin                 // Host word valid now
                        if (txFull[curPortSend])
                            sendOverflow <= 1'b1;
                        if (wordCnt == ethSwitchPkg::frameBeginWord)
                            sendFirstByte <= sendWord[7:0];
                        if (wordCnt == ethSwitchPkg::frameTypeWord)
                            sendIpv4 <= (sendWord == 16'h0008);   // 0x0800 swapped
                    end
                    if (strobe[2])
                        wordCnt <= wordCnt + 12'd1;
                end else begin
                    // Host ended the packet, close it with the info word
                    txInfoOut <= '{overflow: sendOverflow, rsvd: 7'd0,
                                   firstByte: sendFirstByte, byteCount: responseByteCount};
                    txInfoWrEn[curPortSend] <= ~txInfoFull[curPortSend];
                    events.pktSent  <= 1'b1;
                    events.sendDone <= 1'b1;
                    state <= ethSwitchPkg::stIdle;
                end
            end

            default: state <= ethSwitchPkg::stIdle;
            endcase
        end
    end

    // Host never sees a receive and a send request at once
    assert property (@(posedge clk) disable iff (rst) !(recvRequest && sendRequest));

    // A word pop always finds data, the PHY writes data before info
    assert property (@(posedge clk) disable iff (rst) !(|(rxRdEn & rxEmpty)));

endmodule

`default_nettype wire

// ==== logic/switchDebugRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module switchDebugRegs (
    input  wire                         clk,
    input  wire                         rst,
    input  ethSwitchPkg::switchEvents_t events,
    input  ethSwitchPkg::switchStatus_t status,
    input  wire [15:0]                  regRaddr,
    output logic [31:0]                 regRdata
);

    logic [15:0] timeNow;           // Cycles since the last receive began
    logic [15:0] timeReceive;
    logic [15:0] timeSend;
    logic [15:0] numValid;
    logic [7:0]  numFlushed;
    logic [7:0]  numSent;

    always_ff @(posedge clk) begin
        if (rst) begin
            timeNow     <= '0;
            timeReceive <= '0;
            timeSend    <= '0;
            numValid    <= '0;
            numFlushed  <= '0;
            numSent     <= '0;
        end else begin
            // Timer restarts with every packet taken from a port
            timeNow <= (events.pktValid | events.pktFlushed) ? 16'd0 : timeNow + 16'd1;
            if (events.recvDone)
                timeReceive <= timeNow;
            if (events.sendDone)
                timeSend <= timeNow;
            if (events.pktValid)
                numValid <= numValid + 16'd1;
            if (events.pktFlushed)
                numFlushed <= numFlushed + 8'd1;
            if (events.pktSent)
                numSent <= numSent + 8'd1;
        end
    end

    // ------------------------------
    // Register window, quadlets 0..7
    // ------------------------------
    always_comb begin
        regRdata = '0;
        if (regRaddr[7:3] == ethSwitchPkg::dbgWindowBase) begin
            case (regRaddr[2:0])
            3'd0:    regRdata = ethSwitchPkg::dbgSignature;
            3'd1:    regRdata = {status, {(32 - $bits(status)){1'b0}}};   // Flags at the top
            3'd3:    regRdata = {numSent, numFlushed, numValid};
            3'd5:    regRdata = {timeSend, timeReceive};
            default: regRdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/ethSwitchTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module ethSwitchTop (
    input  wire              clk,
    input  wire              rst,
    // PHY receive side
    input  wire [1:0]        rxWrEn,
    input  wire [1:0][15:0]  rxWord,
    input  wire [1:0]        rxInfoWrEn,
    input  ethSwitchPkg::recvInfo_t [1:0] rxInfo,
    // PHY transmit side
    input  wire [1:0]        txRdEn,
    output logic [1:0][15:0] txWord,
    output logic [1:0]       txEmpty,
    input  wire [1:0]        txInfoRdEn,
    output ethSwitchPkg::sendInfo_t [1:0] txInfo,
    output logic [1:0]       txInfoEmpty,
    input  wire [1:0]        portUp,
    // Host side
    input  wire              sendReq,
    output logic             isForward,
    input  wire              responseRequired,
    input  wire [15:0]       responseByteCount,
    output logic             recvRequest,
    input  wire              recvBusy,
    output logic             recvReady,
    output logic [15:0]      recvWord,
    output logic             sendRequest,
    input  wire              sendBusy,
    output logic             sendReady,
    input  wire [15:0]       sendWord,
    // Register read
    input  wire [15:0]       regRaddr,
    output logic [31:0]      regRdata
);

    logic [1:0]        rxRdEn, rxInfoRdEn, rxEmpty, rxInfoEmpty;
    logic [1:0][15:0]  rxWordOut;
    logic [1:0]        txWrEn, txInfoWrEn, txFull, txInfoFull;
    logic [15:0]       txWordIn;                    // Shared by both send FIFOs
    ethSwitchPkg::recvInfo_t [1:0] rxInfoOut;
    ethSwitchPkg::sendInfo_t       txInfoIn;
    ethSwitchPkg::switchEvents_t   events;
    ethSwitchPkg::switchStatus_t   status;

    // Four queues per port
    for (genvar p = 0; p < 2; p++) begin : genPort
        portFifo #(.width(16), .depth(ethSwitchPkg::fifoDataDepth)) rxDataFifo (
            .clk, .rst, .wrEn(rxWrEn[p]), .wrData(rxWord[p]), .rdEn(rxRdEn[p]),
            .rdData(rxWordOut[p]), .full(), .empty(rxEmpty[p]));
        portFifo #(.width(32), .depth(ethSwitchPkg::fifoInfoDepth)) rxInfoFifo (
            .clk, .rst, .wrEn(rxInfoWrEn[p]), .wrData(rxInfo[p]), .rdEn(rxInfoRdEn[p]),
            .rdData(rxInfoOut[p]), .full(), .empty(rxInfoEmpty[p]));
        portFifo #(.width(16), .depth(ethSwitchPkg::fifoDataDepth)) txDataFifo (
            .clk, .rst, .wrEn(txWrEn[p]), .wrData(txWordIn), .rdEn(txRdEn[p]),
            .rdData(txWord[p]), .full(txFull[p]), .empty(txEmpty[p]));
        portFifo #(.width(32), .depth(ethSwitchPkg::fifoInfoDepth)) txInfoFifo (
            .clk, .rst, .wrEn(txInfoWrEn[p]), .wrData(txInfoIn), .rdEn(txInfoRdEn[p]),
            .rdData(txInfo[p]), .full(txInfoFull[p]), .empty(txInfoEmpty[p]));
    end

    ethPortSwitch uSwitch (
        .clk, .rst, .portUp,
        .rxEmpty, .rxInfoEmpty, .rxWordIn(rxWordOut), .rxInfoIn(rxInfoOut),
        .rxRdEn, .rxInfoRdEn,
        .txFull, .txInfoFull, .txWrEn, .txInfoWrEn,
        .txWordOut(txWordIn), .txInfoOut(txInfoIn),
        .sendReq, .recvBusy, .sendBusy, .sendWord, .responseRequired, .responseByteCount,
        .recvRequest, .recvReady, .recvWord, .sendRequest, .sendReady, .isForward,
        .events, .status);

    switchDebugRegs uDebug (
        .clk, .rst, .events, .status, .regRaddr, .regRdata);

endmodule

`default_nettype wire

// ==== testbench/tbEthSwitch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbEthSwitch;

    localparam int clkPeriod    = 20;
    localparam int txDepth      = 64;             // Send data FIFO words
    localparam int numValidPkts = 12;
    localparam int numFlushPkts = 6;
    localparam int numRespPkts  = 4;
    localparam int maxPktWords  = 30;             // Frames of up to 60 bytes
    // Every word of every test, plus the overflow burst
    localparam int wordBudget = (2 * numValidPkts + numFlushPkts + 2 * numRespPkts + 8)
                              * maxPktWords + txDepth + 8;
    localparam int watchdogCycles = 200 * wordBudget;

    logic clk = 1'b0;
    logic rst;
    logic [1:0]                    rxWrEn;
    logic [1:0][15:0]              rxWord;
    logic [1:0]                    rxInfoWrEn;
    ethSwitchPkg::recvInfo_t [1:0] rxInfo;
    logic [1:0]                    txRdEn;
    logic [1:0][15:0]              txWord;
    logic [1:0]                    txEmpty;
    logic [1:0]                    txInfoRdEn;
    ethSwitchPkg::sendInfo_t [1:0] txInfo;
    logic [1:0]                    txInfoEmpty;
    logic [1:0]                    portUp;
    logic        sendReq;
    logic        isForward;
    logic        responseRequired;
    logic [15:0] responseByteCount;
    logic        recvRequest;
    logic        recvBusy;
    logic        recvReady;
    logic [15:0] recvWord;
    logic        sendRequest;
    logic        sendBusy;
    logic        sendReady;
    logic [15:0] sendWord;
    logic [15:0] regRaddr;
    logic [31:0] regRdata;

    // ------------------------------
    // Reference model state
    // ------------------------------
    logic [15:0] expRecv [$];       // Host-side words, in delivery order
    logic [15:0] expTx [$];         // Byte-swapped words on the send FIFO
    logic [31:0] expTxInfo [$];
    int curPort;                    // Port the switch is parked on
    int cntValid;
    int cntFlushed;
    int cntSent;
    int errors;
    int checks;
    int testNum;
    int testErrors;

    ethSwitchTop dut (.*);

    always #(clkPeriod / 2) clk = ~clk;

    // Step to the next cycle, inputs change just after the edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic expectEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic startTest();
        testNum++;
        testErrors = errors;
    endtask

    task automatic reportTest(input string name);
        $display("Test %0d %s: %0d errors", testNum, name, errors - testErrors);
    endtask

    // Window quadlet q sits at 0x98 + q
    task automatic readReg(input int quadlet, output logic [31:0] val);
        regRaddr = 16'h0098 + 16'(quadlet);
        #1;
        val = regRdata;
    endtask

    // PHY receive: data words first, info word last
    task automatic pushPacket(input int port, input int nBytes, input bit flush);
        int nWords;
        logic [15:0] w;
        logic [7:0] first;
        nWords = (nBytes + 1) / 2;              // Odd count leaves a half word
        first  = 8'd0;
        for (int i = 0; i < nWords; i++) begin
            w = 16'($urandom);
            if (i == 0)
                first = w[15:8];                // First byte on the wire
            if (!flush)
                expRecv.push_back(w);
            rxWord[port] = w;
            rxWrEn[port] = 1'b1;
            tick();
        end
        rxWrEn[port]     = 1'b0;
        rxInfo[port]     = {flush, 7'd0, first, 4'd0, 12'(nBytes)};
        rxInfoWrEn[port] = 1'b1;
        tick();
        rxInfoWrEn[port] = 1'b0;
        if (flush)
            cntFlushed++;
        else
            cntValid++;
    endtask

    // Host receive, ends on sendRequest or once recvReady stays quiet
    task automatic receivePacket(input int nBytes, input bit respond, input int respBytes);
        int waited;
        int got;
        int quiet;
        logic [31:0] exp;
        waited = 0;
        while (!recvRequest && waited < 40) begin
            tick();
            waited++;
        end
        assert (recvRequest)
        else begin
            errors++;
            $display("No recvRequest arrived for a valid %0d-byte packet", nBytes);
        end
        if (!recvRequest)
            return;
        recvBusy          = 1'b1;
        responseRequired  = respond;
        responseByteCount = 16'(respBytes);
        got   = 0;
        quiet = 0;
        while (quiet < 8 && !sendRequest) begin
            tick();
            recvBusy = 1'b0;                    // Keeps a queued packet waiting
            if (recvReady) begin
                if (expRecv.size() == 0) begin
                    errors++;
                    $display("recvReady pulsed with no word left in the model");
                end else begin
                    exp = 32'(expRecv.pop_front());
                    expectEq(32'(recvWord), exp, "recvWord");
                end
                got++;
                quiet = 0;
            end else
                quiet++;
        end
        responseRequired = 1'b0;
        expectEq(32'(got), 32'((nBytes + 1) / 2), "recvReady pulses");
        if (respond)
            expectEq(32'(sendRequest), 1, "sendRequest after response request");
    endtask

    // Host send; word goes out the cycle after sendReady
    task automatic sendPacket(input int nWords, input int respBytes, input int freeSpace);
        int idx;
        int written;
        logic readyPrev;
        logic ovf;
        logic [15:0] w;
        logic [7:0] first;
        if (!sendRequest)
            return;
        sendBusy  = 1'b1;
        idx       = 0;
        written   = 0;
        readyPrev = 1'b0;
        first     = 8'd0;
        while (idx < nWords) begin
            tick();
            if (readyPrev) begin
                w        = 16'($urandom);
                sendWord = w;
                if (idx == 0)
                    first = w[7:0];
                if (written < freeSpace) begin   // Rest is dropped on overflow
                    expTx.push_back({w[7:0], w[15:8]});
                    written++;
                end
                idx++;
            end
            readyPrev = sendReady;
        end
        tick();
        sendBusy = 1'b0;                        // Ends the packet
        ovf = (nWords > freeSpace);
        expTxInfo.push_back({ovf, 7'd0, first, 16'(respBytes)});
        cntSent++;
        repeat (4) tick();
    endtask

    task automatic startForward();
        int waited;
        waited  = 0;
        sendReq = 1'b1;
        while (!sendRequest && waited < 20) begin
            tick();
            waited++;
        end
        sendReq = 1'b0;
        assert (sendRequest)
        else begin
            errors++;
            $display("Forward request on port %0d got no sendRequest", curPort);
        end
        expectEq(32'(isForward), 1, "isForward during forward");
    endtask

    // PHY transmit: drain data, then info, of one port
    task automatic checkTx(input int port);
        logic [31:0] exp;
        int n;
        n = 0;
        while (!txEmpty[port] && n < 2 * txDepth) begin
            if (expTx.size() == 0) begin
                errors++;
                $display("Extra word on send port %0d", port);
            end else begin
                exp = 32'(expTx.pop_front());
                expectEq(32'(txWord[port]), exp, "send word");
            end
            txRdEn[port] = 1'b1;
            tick();
            n++;
        end
        txRdEn[port] = 1'b0;
        expectEq(32'(expTx.size()), 0, "send words still missing");
        while (!txInfoEmpty[port] && n < 4 * txDepth) begin
            if (expTxInfo.size() == 0) begin
                errors++;
                $display("Extra info word on send port %0d", port);
            end else begin
                exp = expTxInfo.pop_front();
                expectEq(txInfo[port], exp, "send info");
            end
            txInfoRdEn[port] = 1'b1;
            tick();
            n++;
        end
        txInfoRdEn[port] = 1'b0;
        expectEq(32'(expTxInfo.size()), 0, "send info still missing");
        expectEq(32'(txEmpty[1 - port]), 1, "other port send FIFO empty");
        expectEq(32'(txInfoEmpty[1 - port]), 1, "other port info FIFO empty");
    endtask

    task automatic watchNoRequest(input int cycles);
        repeat (cycles) begin
            tick();
            assert (!recvRequest)
            else begin
                errors++;
                $display("recvRequest rose for a flushed packet");
            end
        end
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
        $display("FAIL: see errors above");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [31:0] val;
        int p;
        int q;
        int n;
        int m;
        int resp;
        int words;
        void'($urandom(32'h98b14193));
        rst = 1'b1;
        rxWrEn = '0;
        rxWord = '0;
        rxInfoWrEn = '0;
        rxInfo = '0;
        txRdEn = '0;
        txInfoRdEn = '0;
        portUp = 2'b11;
        sendReq = 1'b0;
        responseRequired = 1'b0;
        responseByteCount = '0;
        recvBusy = 1'b0;
        sendBusy = 1'b0;
        sendWord = '0;
        regRaddr = '0;
        curPort = 0;
        cntValid = 0;
        cntFlushed = 0;
        cntSent = 0;
        errors = 0;
        checks = 0;
        testNum = 0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        startTest();
        expectEq(32'(recvRequest), 0, "recvRequest after reset");
        expectEq(32'(recvReady), 0, "recvReady after reset");
        expectEq(32'(sendRequest), 0, "sendRequest after reset");
        expectEq(32'(sendReady), 0, "sendReady after reset");
        expectEq(32'(isForward), 0, "isForward after reset");
        expectEq(32'({txEmpty, txInfoEmpty}), 32'hf, "send FIFOs after reset");
        readReg(0, val);
        expectEq(val, 32'h32474244, "debug signature");
        readReg(3, val);
        expectEq(val, 0, "debug counts after reset");
        readReg(5, val);
        expectEq(val, 0, "debug times after reset");
        regRaddr = 16'h00a0;                    // Just past the window
        #1;
        expectEq(regRdata, 0, "read outside window");
        reportTest("reset state");

        startTest();
        for (int i = 0; i < numValidPkts; i++) begin
            p = int'($urandom % 2);
            n = 1 + int'($urandom % 60);
            pushPacket(p, n, 1'b0);
            if ($urandom % 2 == 1) begin        // Second frame queued on the other port
                m = 1 + int'($urandom % 60);
                pushPacket(1 - p, m, 1'b0);
                receivePacket(n, 1'b0, 0);
                receivePacket(m, 1'b0, 0);
                curPort = 1 - p;
            end else begin
                receivePacket(n, 1'b0, 0);
                curPort = p;
            end
        end
        expectEq(32'(expRecv.size()), 0, "words never delivered");
        reportTest("valid packets");

        startTest();
        for (int i = 0; i < numFlushPkts; i++) begin
            p = int'($urandom % 2);
            n = 1 + int'($urandom % 60);
            pushPacket(p, n, 1'b1);
            curPort = p;
            watchNoRequest((n + 1) / 2 + 8);
        end
        readReg(3, val);
        expectEq(32'(val[23:16]), 32'(cntFlushed), "flushed count");
        // Clean frame behind the flushes shows the data FIFO drained
        n = 1 + int'($urandom % 60);
        pushPacket(curPort, n, 1'b0);
        receivePacket(n, 1'b0, 0);
        reportTest("flushed packets");

        startTest();
        for (int i = 0; i < numRespPkts; i++) begin
            p    = int'($urandom % 2);
            n    = 1 + int'($urandom % 60);
            resp = 1 + int'($urandom % 40);
            pushPacket(p, n, 1'b0);
            curPort = p;
            receivePacket(n, 1'b1, resp);
            sendPacket((resp + 1) / 2, resp, txDepth);
            checkTx(p);
        end
        reportTest("responses");

        startTest();
        for (int i = 0; i < 2; i++) begin
            if (i == 1) begin                   // Park on the other port first
                q = 1 - curPort;
                n = 1 + int'($urandom % 60);
                pushPacket(q, n, 1'b0);
                receivePacket(n, 1'b0, 0);
                curPort = q;
            end
            resp = 2 + int'($urandom % 40);
            responseByteCount = 16'(resp);
            startForward();
            sendPacket((resp + 1) / 2, resp, txDepth);
            checkTx(curPort);
            expectEq(32'(isForward), 0, "isForward after forward");
        end
        reportTest("forwards");

        startTest();
        words = txDepth + 1 + int'($urandom % 8);
        responseByteCount = 16'(2 * words);
        startForward();
        sendPacket(words, 2 * words, txDepth);
        checkTx(curPort);
        readReg(3, val);
        expectEq(val, {cntSent[7:0], cntFlushed[7:0], cntValid[15:0]}, "debug counts");
        readReg(1, val);
        // Status flags sit in the top bits and the IPv4 bit stays masked
        expectEq(val & 32'hf7ff_ffff, {curPort[0], curPort[0], 1'b1, 1'b0, 28'd0},
                 "debug status");
        reportTest("send overflow");

        $display("Tests: %0d, checks: %0d, errors: %0d", testNum, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/ethSwitchPkg.sv
logic/portFifo.sv
logic/ethPortSwitch.sv
logic/switchDebugRegs.sv
logic/ethSwitchTop.sv
testbench/tbEthSwitch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -f sim.log
verilator --binary --timing --assert --top-module tbEthSwitch -f verilog.f -o tbEthSwitch \
    && ./obj_dir/tbEthSwitch | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "No pass line in sim.log"; exit 1; }
echo "Simulation passed"
exit 0
